//--- design/lsu_access_tracker.sv
////////////////////////////////////////
// lsu access tracker
// keeps the attributes of the granted
// access and the idle / wait-rvalid FSM
// gates requests and drives the stall
// and busy outputs
////////////////////////////////////////

module lsu_access_tracker (
  input  logic      clk,
  input  logic      rst_n,

  input  logic      req_i,       // request from ex stage
  input  logic      gnt_i,
  input  logic      rvalid_i,

  output logic      req_o,       // request on the memory port
  output logic      ready_ex_o,
  output logic      ready_wb_o,
  output logic      busy_o,

  lsu_attr_if.dst   new_attr,    // access being presented
  lsu_attr_if.src   out_attr     // access waiting for rvalid
);

  typedef enum logic {
    ST_IDLE,
    ST_WAIT    // one access granted, rvalid pending
  } state_e;

  state_e                       state_q;
  state_e                       state_d;
  lsu_types_pkg::access_attr_t  attr_q;
  logic                         issue;    // request passed and granted this cycle

  ////////////////////////////////////////
  // request gating and FSM
  ////////////////////////////////////////

  // pass through when idle, or when the pending access completes now
  assign req_o = req_i && ((state_q == ST_IDLE) || rvalid_i);
  assign issue = req_o && gnt_i;

  always_comb
  begin
    state_d = state_q;
    if (issue)
      state_d = ST_WAIT;              // also covers back-to-back in rvalid cycle
    else if ((state_q == ST_WAIT) && rvalid_i)
      state_d = ST_IDLE;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  // attribute register, loads with every grant
  always_ff @(posedge clk)
  begin
    if (gnt_i)
      attr_q <= new_attr.info;
  end

  assign out_attr.info = attr_q;

  // ex stalls while it requests and has no grant yet
  assign ready_ex_o = !req_i || issue;

  // wb stalls until the outstanding rvalid
  assign ready_wb_o = (state_q == ST_IDLE) || rvalid_i;

  assign busy_o = (state_q == ST_WAIT) || req_o;

endmodule

//--- design/lsu_attr_if.sv
////////////////////////////////////////
// access attribute interface
// carries one attribute set from the
// stage that owns it to the stage that
// consumes it
////////////////////////////////////////

interface lsu_attr_if;

  // size, offset, extension, direction and split flag
  lsu_types_pkg::access_attr_t info;

  // owner side
  modport src (
    output info
  );

  // consumer side
  modport dst (
    input  info
  );

endinterface

//--- design/lsu_cfg_pkg.sv
////////////////////////////////////////
// lsu config package
// widths and vector types of the fixed
// RV32 data port: word, byte lanes and
// byte offset
////////////////////////////////////////

package lsu_cfg_pkg;

  // data port geometry, 32-bit word only
  parameter int unsigned WORD_W  = 32;  // data and address word
  parameter int unsigned BYTES_W = 4;   // byte lanes per word
  parameter int unsigned OFFS_W  = 2;   // byte offset inside a word

  // data or address word
  typedef logic [WORD_W-1:0]  word_t;

  typedef logic [BYTES_W-1:0] be_t;     // byte enables, one per lane
  typedef logic [OFFS_W-1:0]  offs_t;   // low address bits

endpackage

//--- design/lsu_load_aligner.sv
////////////////////////////////////////
// lsu load aligner
// picks the loaded byte, half or word
// at the recorded offset, joins the two
// halves of a split load and extends
// the result, holding it between rvalids
////////////////////////////////////////

module lsu_load_aligner (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                rvalid_i,
  input  lsu_cfg_pkg::word_t  rdata_i,   // raw word from memory

  output lsu_cfg_pkg::word_t  rdata_o,   // result to register file

  lsu_attr_if.dst             attr       // attributes of the returning access
);

  lsu_cfg_pkg::word_t rdata_q;      // held result, or first word of a split load
  logic               join_pend_q;  // first part of a split load seen
  lsu_cfg_pkg::word_t word_val;
  logic [15:0]        half_val;
  logic [7:0]         byte_val;
  logic               half_fill;    // bit copied into the upper bits
  logic               byte_fill;
  lsu_cfg_pkg::word_t result;

  ////////////////////////////////////////
  // lane select and word join
  ////////////////////////////////////////
  always_comb
  begin
    case (attr.info.offset)
      2'b00:   word_val = rdata_i;
      2'b01:   word_val = {rdata_i[7:0],  rdata_q[31:8]};   // upper 3 bytes came first
      2'b10:   word_val = {rdata_i[15:0], rdata_q[31:16]};
      default: word_val = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (attr.info.offset)
      2'b00:   half_val = rdata_i[15:0];
      2'b01:   half_val = rdata_i[23:8];
      2'b10:   half_val = rdata_i[31:16];
      default: half_val = {rdata_i[7:0], rdata_q[31:24]};   // crosses into next word
    endcase
  end

  assign byte_val = rdata_i[8*attr.info.offset +: 8];

  // extension, unused code 2'b11 falls back to sign
  always_comb
  begin
    case (attr.info.ext)
      lsu_types_pkg::EXT_ZERO:
      begin
        half_fill = 1'b0;
        byte_fill = 1'b0;
      end
      lsu_types_pkg::EXT_ONES:
      begin
        half_fill = 1'b1;
        byte_fill = 1'b1;
      end
      default:
      begin
        half_fill = half_val[15];
        byte_fill = byte_val[7];
      end
    endcase
  end

  always_comb
  begin
    case (attr.info.size)
      lsu_types_pkg::SIZE_WORD: result = word_val;
      lsu_types_pkg::SIZE_HALF: result = {{16{half_fill}}, half_val};
      default:                  result = {{24{byte_fill}}, byte_val};
    endcase
  end

  ////////////////////////////////////////
  // held result
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdata_q     <= '0;
      join_pend_q <= 1'b0;
    end
    else if (rvalid_i && !attr.info.we)   // stores leave the held value alone
    begin
      if (attr.info.split && !join_pend_q)
        rdata_q <= rdata_i;               // keep raw first word for the join
      else
        rdata_q <= result;
      join_pend_q <= attr.info.split && !join_pend_q;
    end
  end

  // live result in the rvalid cycle, held value otherwise
  assign rdata_o = rvalid_i ? result : rdata_q;

endmodule

//--- design/lsu_request_gen.sv
////////////////////////////////////////
// lsu request generator
// forms address, byte enables, rotated
// store data and the word-crossing flag
// for the access in the ex stage
// purely combinational
////////////////////////////////////////

module lsu_request_gen (
  input  lsu_cfg_pkg::word_t    operand_a_i,
  input  lsu_cfg_pkg::word_t    operand_b_i,
  input  logic                  addr_useincr_i,   // a + b when set, else a
  input  lsu_types_pkg::size_e  size_i,
  input  lsu_types_pkg::ext_e   ext_i,
  input  logic                  we_i,
  input  lsu_cfg_pkg::offs_t    reg_offset_i,     // byte offset of store data in register
  input  lsu_cfg_pkg::word_t    wdata_i,
  input  logic                  misaligned_ex_i,  // second part of a split access
  input  logic                  req_i,

  output lsu_cfg_pkg::word_t    addr_o,
  output lsu_cfg_pkg::be_t      be_o,
  output lsu_cfg_pkg::word_t    wdata_o,
  output logic                  misaligned_o,     // first part crosses a word

  lsu_attr_if.src               attr
);

  lsu_cfg_pkg::word_t addr;
  lsu_cfg_pkg::offs_t offs;
  lsu_cfg_pkg::offs_t rot;     // lanes to rotate store data by

  assign addr = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign offs = addr[1:0];

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////
  always_comb
  begin
    case (size_i)
      lsu_types_pkg::SIZE_WORD:
      begin
        if (!misaligned_ex_i)
        begin
          case (offs)             // first part, lanes from offset up
            2'b00:   be_o = 4'b1111;
            2'b01:   be_o = 4'b1110;
            2'b10:   be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end
        else
        begin
          case (offs)             // second part, lanes below offset
            2'b00:   be_o = 4'b0000;  // never split
            2'b01:   be_o = 4'b0001;
            2'b10:   be_o = 4'b0011;
            default: be_o = 4'b0111;
          endcase
        end
      end

      lsu_types_pkg::SIZE_HALF:
      begin
        if (!misaligned_ex_i)
        begin
          case (offs)
            2'b00:   be_o = 4'b0011;
            2'b01:   be_o = 4'b0110;
            2'b10:   be_o = 4'b1100;
            default: be_o = 4'b1000;  // low byte only, rest goes next word
          endcase
        end
        else
          be_o = 4'b0001;         // upper byte of a half at offset 3
      end

      default:                    // both byte codes
      begin
        be_o = 4'b0001 << offs;
      end
    endcase
  end

  ////////////////////////////////////////
  // store data onto byte lanes
  ////////////////////////////////////////
  assign rot = offs - reg_offset_i;   // wraps mod 4

  always_comb
  begin
    case (rot)
      2'b00:   wdata_o = wdata_i;
      2'b01:   wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  // word-crossing check, first part only
  always_comb
  begin
    misaligned_o = 1'b0;
    if (req_i && !misaligned_ex_i)
    begin
      if (size_i == lsu_types_pkg::SIZE_WORD)
        misaligned_o = (offs != 2'b00);
      else if (size_i == lsu_types_pkg::SIZE_HALF)
        misaligned_o = (offs == 2'b11);
    end
  end

  assign addr_o = addr;

  // attributes of the access now on the port
  assign attr.info.size   = size_i;
  assign attr.info.offset = offs;
  assign attr.info.ext    = ext_i;
  assign attr.info.we     = we_i;
  assign attr.info.split  = misaligned_o | misaligned_ex_i;

endmodule

//--- design/lsu_top.sv
////////////////////////////////////////
// lsu top
// data memory load/store unit of the
// RV32 pipeline, request side, access
// tracker and load aligner
////////////////////////////////////////

module lsu_top (
  input  logic                  clk,
  input  logic                  rst_n,

  // data memory port
  output logic                  data_req_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  output lsu_cfg_pkg::word_t    data_addr_o,
  output logic                  data_we_o,
  output lsu_cfg_pkg::be_t      data_be_o,
  output lsu_cfg_pkg::word_t    data_wdata_o,
  input  lsu_cfg_pkg::word_t    data_rdata_i,

  // from ex stage
  input  logic                  data_we_ex_i,
  input  lsu_types_pkg::size_e  data_type_ex_i,
  input  lsu_cfg_pkg::word_t    data_wdata_ex_i,
  input  lsu_cfg_pkg::offs_t    data_reg_offset_ex_i,
  input  lsu_types_pkg::ext_e   data_sign_ext_ex_i,
  input  logic                  data_req_ex_i,
  input  lsu_cfg_pkg::word_t    operand_a_ex_i,
  input  lsu_cfg_pkg::word_t    operand_b_ex_i,
  input  logic                  addr_useincr_ex_i,
  input  logic                  data_misaligned_ex_i,  // second part, from controller

  output lsu_cfg_pkg::word_t    data_rdata_ex_o,
  output logic                  data_misaligned_o,     // to controller, replay needed
  output logic                  lsu_ready_ex_o,
  output logic                  lsu_ready_wb_o,
  output logic                  busy_o
);

  lsu_attr_if req_attr ();   // access on the port now
  lsu_attr_if rsp_attr ();   // access waiting for rvalid

  lsu_request_gen i_request_gen (
    .operand_a_i     (operand_a_ex_i),
    .operand_b_i     (operand_b_ex_i),
    .addr_useincr_i  (addr_useincr_ex_i),
    .size_i          (data_type_ex_i),
    .ext_i           (data_sign_ext_ex_i),
    .we_i            (data_we_ex_i),
    .reg_offset_i    (data_reg_offset_ex_i),
    .wdata_i         (data_wdata_ex_i),
    .misaligned_ex_i (data_misaligned_ex_i),
    .req_i           (data_req_ex_i),
    .addr_o          (data_addr_o),
    .be_o            (data_be_o),
    .wdata_o         (data_wdata_o),
    .misaligned_o    (data_misaligned_o),
    .attr            (req_attr.src)
  );

  lsu_access_tracker i_access_tracker (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (data_req_ex_i),
    .gnt_i      (data_gnt_i),
    .rvalid_i   (data_rvalid_i),
    .req_o      (data_req_o),
    .ready_ex_o (lsu_ready_ex_o),
    .ready_wb_o (lsu_ready_wb_o),
    .busy_o     (busy_o),
    .new_attr   (req_attr.dst),
    .out_attr   (rsp_attr.src)
  );

  lsu_load_aligner i_load_aligner (
    .clk      (clk),
    .rst_n    (rst_n),
    .rvalid_i (data_rvalid_i),
    .rdata_i  (data_rdata_i),
    .rdata_o  (data_rdata_ex_o),
    .attr     (rsp_attr.dst)
  );

  assign data_we_o = data_we_ex_i;   // direction goes straight to the port

endmodule

//--- design/lsu_types_pkg.sv
////////////////////////////////////////
// lsu access types
// access size and load extension codes
// plus the attribute set that follows
// an access from grant to rvalid
////////////////////////////////////////

package lsu_types_pkg;

  // access size as sent by the ex stage
  typedef enum logic [1:0] {
    SIZE_WORD     = 2'b00,
    SIZE_HALF     = 2'b01,
    SIZE_BYTE     = 2'b10,
    SIZE_BYTE_ALT = 2'b11  // same as byte
  } size_e;

  // load extension mode, code 2'b11 acts as sign
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,
    EXT_SIGN = 2'b01,
    EXT_ONES = 2'b10
  } ext_e;

  ////////////////////////////////////////
  // attributes of one access, 8 bits
  ////////////////////////////////////////
  typedef struct packed {
    size_e               size;    // word, half or byte
    lsu_cfg_pkg::offs_t  offset;  // low address bits of the access
    ext_e                ext;     // how to fill the upper load bits
    logic                we;      // store when set
    logic                split;   // either part of a word-crossing pair
  } access_attr_t;

endpackage

//--- flist.f
design/lsu_cfg_pkg.sv
design/lsu_types_pkg.sv
design/lsu_attr_if.sv
design/lsu_request_gen.sv
design/lsu_access_tracker.sv
design/lsu_load_aligner.sv
design/lsu_top.sv
verification/lsu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the lsu testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f flist.f --top-module lsu_tb \
  -Mdir "${build_dir}" -o lsu_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./${build_dir}/lsu_tb_sim" > "${log_file}" 2>&1
sim_status=$?
cat "${log_file}"
if [ ${sim_status} -ne 0 ]; then
  echo "simulation exited with status ${sim_status}"
  exit 1
fi

if grep -qx "Test passed" "${log_file}"; then
  echo "lsu simulation: PASS"
  exit 0
else
  echo "lsu simulation: FAIL"
  exit 1
fi

//--- verification/lsu_tb.sv
////////////////////////////////////////
// lsu testbench
// random loads and stores against a
// byte memory model, with split replay,
// grant delay and rvalid latency
////////////////////////////////////////

module lsu_tb;

  localparam int unsigned NUM_TESTS  = 400;
  localparam int unsigned MEM_BYTES  = 256;
  localparam int unsigned CLK_PERIOD = 40;
  localparam logic [31:0] SEED       = 32'hf07d_b51a;

  logic                  clk, rst_n;
  logic                  data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  lsu_cfg_pkg::word_t    data_addr_o, data_wdata_o, data_rdata_i, data_rdata_ex_o;
  lsu_cfg_pkg::be_t      data_be_o;
  logic                  data_we_ex_i, data_req_ex_i, addr_useincr_ex_i, data_misaligned_ex_i;
  lsu_types_pkg::size_e  data_type_ex_i;
  lsu_types_pkg::ext_e   data_sign_ext_ex_i;
  lsu_cfg_pkg::word_t    data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i;
  lsu_cfg_pkg::offs_t    data_reg_offset_ex_i;
  logic                  data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o;

  logic [7:0]  mem [MEM_BYTES];      // written through the port
  logic [7:0]  ref_mem [MEM_BYTES];  // written from the access rules
  logic [31:0] rng_q;
  int unsigned tests_issued, gnt_wait, out_count;

  // access presented by the ex stage
  logic                         op_valid, gap, cur_part, cur_incr;
  lsu_types_pkg::access_attr_t  cur;
  lsu_cfg_pkg::word_t           cur_addr, cur_wdata, cur_op_a, cur_op_b, cur_load_exp;
  lsu_cfg_pkg::offs_t           cur_reg_off;

  // access waiting for rvalid
  logic                         out_valid, out_last, held_known;
  lsu_types_pkg::access_attr_t  out_attr;
  lsu_cfg_pkg::word_t           out_rdata, out_exp, held_exp;

  lsu_top i_lsu_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rng_q = xorshift(rng_q);
    return rng_q;
  endfunction

  function automatic int unsigned access_bytes(input lsu_types_pkg::size_e s);
    case (s)
      lsu_types_pkg::SIZE_WORD: return 4;
      lsu_types_pkg::SIZE_HALF: return 2;
      default:                  return 1;
    endcase
  endfunction

  function automatic logic crosses_word(input lsu_types_pkg::size_e s,
                                        input lsu_cfg_pkg::offs_t o);
    return (int'(o) + access_bytes(s)) > 4;   // last byte lands in the next word
  endfunction

  function automatic int unsigned mem_index(input lsu_cfg_pkg::word_t a);
    return a % MEM_BYTES;
  endfunction

  // first part takes lanes inside this word, second part the overflow
  function automatic lsu_cfg_pkg::be_t lanes_of(input lsu_types_pkg::size_e s,
                                                input lsu_cfg_pkg::offs_t o, input logic part);
    lsu_cfg_pkg::be_t be;
    int unsigned      pos;
    be = '0;
    for (int unsigned i = 0; i < access_bytes(s); i++)
    begin
      pos = int'(o) + i;
      if ((pos < 4) == !part)
        be[pos % 4] = 1'b1;
    end
    return be;
  endfunction

  // lane at address offset o carries register byte reg_off
  function automatic lsu_cfg_pkg::word_t lanes_wdata(input lsu_cfg_pkg::word_t w,
                                                     input lsu_cfg_pkg::offs_t o,
                                                     input lsu_cfg_pkg::offs_t reg_off);
    lsu_cfg_pkg::word_t r;
    int unsigned        src;
    for (int unsigned lane = 0; lane < 4; lane++)
    begin
      src = (lane + 4 + int'(reg_off) - int'(o)) % 4;
      r[8 * lane +: 8] = w[8 * src +: 8];
    end
    return r;
  endfunction

  // little-endian bytes from addr, then zero, sign or ones fill
  function automatic lsu_cfg_pkg::word_t load_value(input lsu_cfg_pkg::word_t addr,
                                                    input lsu_types_pkg::size_e s,
                                                    input lsu_types_pkg::ext_e e);
    lsu_cfg_pkg::word_t v;
    int unsigned        n;
    logic               fill;
    n = access_bytes(s);
    v = '0;
    for (int unsigned i = 0; i < n; i++)
      v[8 * i +: 8] = ref_mem[mem_index(addr + i)];
    case (e)
      lsu_types_pkg::EXT_ZERO: fill = 1'b0;
      lsu_types_pkg::EXT_ONES: fill = 1'b1;
      default:                 fill = v[8 * n - 1];   // sign, also the spare code
    endcase
    for (int unsigned b = 8 * n; b < 32; b++)
      v[b] = fill;
    return v;
  endfunction

  function automatic lsu_cfg_pkg::word_t read_word(input logic from_ref,
                                                   input lsu_cfg_pkg::word_t a);
    lsu_cfg_pkg::word_t w;
    int unsigned        base;
    base = mem_index({a[31:2], 2'b00});
    for (int unsigned lane = 0; lane < 4; lane++)
      w[8 * lane +: 8] = from_ref ? ref_mem[base + lane] : mem[base + lane];
    return w;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input lsu_cfg_pkg::word_t exp,
                            input lsu_cfg_pkg::word_t act);
    if (act !== exp)
      stop_on_error($sformatf("Mismatch %s (access %0d): expected %h, actual %h",
                              name, tests_issued, exp, act));
  endtask

  task automatic check_be(input string name, input lsu_cfg_pkg::be_t exp,
                          input lsu_cfg_pkg::be_t act);
    if (act !== exp)
      stop_on_error($sformatf("Mismatch %s (access %0d): expected %b, actual %b",
                              name, tests_issued, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      stop_on_error($sformatf("Mismatch %s (access %0d): expected %b, actual %b",
                              name, tests_issued, exp, act));
  endtask

  ////////////////////////////////////////
  // ex stage, controller and memory
  ////////////////////////////////////////
  task automatic new_access();
    logic [31:0] r;
    if (tests_issued == NUM_TESTS)
      op_valid = 1'b0;
    else
    begin
      r           = next_rand();
      cur.we      = r[0];
      cur.size    = lsu_types_pkg::size_e'(r[2:1]);
      cur.ext     = lsu_types_pkg::ext_e'(r[4:3]);
      cur_reg_off = r[6:5];
      cur_incr    = r[7];
      gap         = (r[10:8] == 3'b000);   // one idle cycle now and then
      cur_addr    = next_rand();
      cur_wdata   = next_rand();
      cur_op_b    = next_rand();
      cur_op_a    = cur_incr ? cur_addr - cur_op_b : cur_addr;
      cur.offset  = cur_addr[1:0];
      cur.split   = crosses_word(cur.size, cur_addr[1:0]);
      cur_part    = 1'b0;
      op_valid    = 1'b1;
      tests_issued++;
      if (cur.we)
        for (int unsigned i = 0; i < access_bytes(cur.size); i++)
          ref_mem[mem_index(cur_addr + i)] = cur_wdata[8 * ((i + cur_reg_off) % 4) +: 8];
      else
        cur_load_exp = load_value(cur_addr, cur.size, cur.ext);
    end
  endtask

  task automatic grant_access();
    int unsigned        base;
    lsu_cfg_pkg::word_t first;
    check_word("request address", cur_addr, data_addr_o);
    check_be("byte enables", lanes_of(cur.size, cur_addr[1:0], cur_part), data_be_o);
    check_word("store lanes", lanes_wdata(cur_wdata, cur_addr[1:0], cur_reg_off), data_wdata_o);
    check_bit("write enable", cur.we, data_we_o);
    base = mem_index({data_addr_o[31:2], 2'b00});
    for (int unsigned lane = 0; lane < 4; lane++)
    begin
      if (data_we_o && data_be_o[lane])
        mem[base + lane] = data_wdata_o[8 * lane +: 8];
      out_rdata[8 * lane +: 8] = mem[base + lane];   // read after write
    end
    out_valid = 1'b1;
    out_count = 1 + next_rand() % 2;                  // rvalid 1 or 2 cycles on
    out_attr  = cur;
    out_last  = !cur.split || cur_part;
    out_exp   = cur_load_exp;
    if (cur.we && out_last)
    begin
      first = cur_part ? cur_addr - 4 : cur_addr;
      check_word("store word", read_word(1'b1, first), read_word(1'b0, first));
      check_word("store next word", read_word(1'b1, first + 4), read_word(1'b0, first + 4));
    end
    if (cur.split && !cur_part)
    begin
      cur_part = 1'b1;            // replay one word up, same offset
      cur_addr = cur_addr + 4;
      cur_op_a = cur_op_a + 4;
    end
    else
      new_access();
    gnt_wait = next_rand() % 4;
  endtask

  task automatic run_cycle();
    logic have_req, rvalid_now, port_req, gnt_now;
    @(negedge clk);
    have_req   = op_valid && !gap;
    rvalid_now = 1'b0;
    if (out_valid)
    begin
      out_count--;
      rvalid_now = (out_count == 0);
    end
    port_req = have_req && (!out_valid || rvalid_now);   // blocked while waiting
    gnt_now  = port_req && (gnt_wait == 0);
    data_req_ex_i        = have_req;
    data_we_ex_i         = cur.we;
    data_type_ex_i       = cur.size;
    data_sign_ext_ex_i   = cur.ext;
    data_wdata_ex_i      = cur_wdata;
    data_reg_offset_ex_i = cur_reg_off;
    data_misaligned_ex_i = cur_part;
    operand_a_ex_i       = cur_op_a;
    operand_b_ex_i       = cur_op_b;
    addr_useincr_ex_i    = cur_incr;
    data_gnt_i           = gnt_now;
    data_rvalid_i        = rvalid_now;
    data_rdata_i         = rvalid_now ? out_rdata : next_rand();
    #(CLK_PERIOD / 4);
    check_bit("data_req_o", port_req, data_req_o);
    check_bit("lsu_ready_ex_o", !have_req || gnt_now, lsu_ready_ex_o);
    check_bit("lsu_ready_wb_o", !out_valid || rvalid_now, lsu_ready_wb_o);
    check_bit("busy_o", out_valid || port_req, busy_o);
    check_bit("data_misaligned_o", have_req && !cur_part && cur.split, data_misaligned_o);
    if (rvalid_now && !out_attr.we && out_last)
      check_word("load result", out_exp, data_rdata_ex_o);
    else if (!rvalid_now && held_known)
      check_word("held result", held_exp, data_rdata_ex_o);
    if (rvalid_now)
    begin
      out_valid = 1'b0;
      if (!out_attr.we)
      begin
        held_known = out_last;    // first part of a split load holds the raw word
        held_exp   = out_exp;
      end
    end
    gap = 1'b0;
    if (gnt_now)
      grant_access();
    else if (port_req)
      gnt_wait--;
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////
  initial
  begin
    rng_q = SEED;
    for (int i = 0; i < MEM_BYTES; i++)
    begin
      mem[i]     = 8'((i * 29) ^ (i >> 3) ^ 8'hc5);
      ref_mem[i] = mem[i];
    end
    {tests_issued, gnt_wait, out_count} = '0;
    {op_valid, gap, cur_part, cur_incr, out_valid, out_last} = '0;
    {cur, out_attr, cur_reg_off} = '0;
    {cur_addr, cur_wdata, cur_op_a, cur_op_b, cur_load_exp, out_rdata, out_exp} = '0;
    held_known = 1'b1;            // held result clears on reset
    held_exp   = '0;
    {data_gnt_i, data_rvalid_i, data_rdata_i} = '0;
    {data_we_ex_i, data_req_ex_i, addr_useincr_ex_i, data_misaligned_ex_i} = '0;
    data_type_ex_i       = lsu_types_pkg::SIZE_WORD;
    data_sign_ext_ex_i   = lsu_types_pkg::EXT_ZERO;
    {data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i, data_reg_offset_ex_i} = '0;
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    run_cycle();                  // idle cycle, checks the state after reset
    new_access();
    while (op_valid || out_valid)
      run_cycle();
    for (int unsigned a = 0; a < MEM_BYTES; a += 4)
      check_word("final memory", read_word(1'b1, a), read_word(1'b0, a));
    $display("Test passed");
    $finish;
  end

  // two parts of at most 5 cycles each plus a gap bound one access
  initial
  begin
    repeat (NUM_TESTS * 12 + 10) @(posedge clk);
    $display("Watchdog expired with accesses still in progress");
    $display("Test failed");
    $fatal(1, "simulation timeout");
  end

endmodule
